/* rtl/video_pkg.sv */
// Shared definitions for the character video path.
// Holds bus widths, the video memory map, the link structs and the FSM encodings.
// Modules use scoped names in their port lists and import the package in the body.

`default_nettype none

package video_pkg;

    localparam int WB_ADDR_WIDTH = 17;                  // Wishbone address bits
    localparam int DATA_WIDTH    = 8;                   // Wishbone data bits
    localparam int VMEM_OFFSET_WIDTH = 11;              // Offset into VRAM or VROM

    localparam logic [WB_ADDR_WIDTH-1:0] VRAM_BASE = 17'h08000;   // Video RAM window
    localparam logic [WB_ADDR_WIDTH-1:0] VROM_BASE = 17'h10000;   // Character ROM window

    // Map an offset into the video RAM window
    function automatic logic [WB_ADDR_WIDTH-1:0] wb_vram_addr(
        input logic [VMEM_OFFSET_WIDTH-1:0] offset
    );
        return VRAM_BASE | WB_ADDR_WIDTH'(offset);
    endfunction

    // Offset is {gfx, code[6:0], row[2:0]}
    function automatic logic [WB_ADDR_WIDTH-1:0] wb_vrom_addr(
        input logic [VMEM_OFFSET_WIDTH-1:0] offset
    );
        return VROM_BASE | WB_ADDR_WIDTH'(offset);
    endfunction

    typedef struct packed {
        logic [13:0] ma;                                // Character pair address
        logic [4:0]  ra;                                // Raster row within glyph
        logic        line_start;                        // First pair of a scan line
        logic        frame_start;                       // First pair of a frame
    } char_pos_t;

    typedef struct packed {
        logic [7:0] even_row;                           // Glyph row of even character
        logic [7:0] odd_row;                            // Glyph row of odd character
        logic       even_rev;                           // Reverse video for even glyph
        logic       odd_rev;                            // Reverse video for odd glyph
        logic       line_start;
        logic       frame_start;
    } glyph_pair_t;

    typedef struct packed {
        logic value;                                    // Pixel on or off
        logic line_start;                               // First pixel of a scan line
        logic frame_start;                              // First pixel of a frame
    } pixel_t;

    typedef enum logic [1:0] {
        EVEN_RAM,                                       // Even character code
        EVEN_ROM,                                       // Even glyph row
        ODD_RAM,                                        // Odd character code
        ODD_ROM                                         // Odd glyph row
    } fetch_stage_e;

    typedef enum logic {
        WB_IDLE,                                        // Ready to issue a strobe
        WB_AWAIT_ACK                                    // Request out, waiting on ack
    } wb_state_e;

endpackage

`default_nettype wire

/* rtl/crtc_timing.sv */
// Character timing generator for the video path.
// Walks pairs across a line, eight raster rows per text row, then text rows per frame.
// Each position is offered on a valid/ready link and advances only when taken.

`default_nettype none

module crtc_timing #(
    parameter int PAIRS_PER_LINE = 20,                  // Character pairs per scan line
    parameter int TEXT_ROWS      = 25                   // Text rows per frame
) (
    input  logic                  wb_clock_i,
    input  logic                  reset_i,
    output video_pkg::char_pos_t  pos_o,                // Current screen position
    output logic                  pos_valid_o,
    input  logic                  pos_ready_i
);
    localparam int PAIR_W = (PAIRS_PER_LINE > 1) ? $clog2(PAIRS_PER_LINE) : 1;
    localparam int ROW_W  = (TEXT_ROWS > 1) ? $clog2(TEXT_ROWS) : 1;

    logic [PAIR_W-1:0] pair_cnt;                        // Pair index within line
    logic [2:0]        ra_cnt;                          // Raster row within glyph
    logic [ROW_W-1:0]  row_cnt;                         // Text row within frame
    logic [13:0]       ma_cnt;                          // Running pair address
    logic [13:0]       line_base;                       // ma of pair 0 in this text row

    logic advance;
    logic last_pair;
    logic last_ra;
    logic last_row;

    assign advance   = pos_valid_o && pos_ready_i;      // Position taken by fetch
    assign last_pair = (pair_cnt == PAIR_W'(PAIRS_PER_LINE - 1));
    assign last_ra   = (ra_cnt == 3'd7);
    assign last_row  = (row_cnt == ROW_W'(TEXT_ROWS - 1));

    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            pos_valid_o <= 1'b0;
            pair_cnt    <= '0;
            ra_cnt      <= '0;
            row_cnt     <= '0;
            ma_cnt      <= '0;
            line_base   <= '0;
        end else begin
            pos_valid_o <= 1'b1;                        // Always a position to offer
            if (advance) begin
                if (!last_pair) begin
                    pair_cnt <= pair_cnt + 1'b1;
                    ma_cnt   <= ma_cnt + 14'd1;
                end else begin
                    pair_cnt <= '0;
                    if (!last_ra) begin
                        ra_cnt <= ra_cnt + 3'd1;
                        ma_cnt <= line_base;            // Same text row again
                    end else begin
                        ra_cnt <= '0;
                        if (last_row) begin
                            row_cnt   <= '0;            // Wrap to top of screen
                            ma_cnt    <= '0;
                            line_base <= '0;
                        end else begin
                            row_cnt   <= row_cnt + 1'b1;
                            ma_cnt    <= ma_cnt + 14'd1;
                            line_base <= ma_cnt + 14'd1;
                        end
                    end
                end
            end
        end
    end

    always_comb begin
        pos_o.ma          = ma_cnt;
        pos_o.ra          = {2'b00, ra_cnt};
        pos_o.line_start  = (pair_cnt == '0);
        pos_o.frame_start = (pair_cnt == '0) && (ra_cnt == 3'd0) && (row_cnt == '0);
    end

endmodule

`default_nettype wire

/* rtl/video_fetch.sv */
// Wishbone B4 pipelined read master for character video.
// Takes one screen position and does four single reads for it.
// Even code, even glyph row, odd code, odd glyph row. Then offers the glyph pair.
// One request is outstanding at a time and wb_cycle_o stays up once raised.

`default_nettype none

module video_fetch (
    input  logic                                wb_clock_i,
    input  logic                                reset_i,
    output logic [video_pkg::WB_ADDR_WIDTH-1:0] wb_addr_o,    // Valid while strobe high
    output logic [video_pkg::DATA_WIDTH-1:0]    wb_data_o,    // Unused write data
    input  logic [video_pkg::DATA_WIDTH-1:0]    wb_data_i,    // Captured on ack
    output logic                                wb_we_o,      // Reads only
    output logic                                wb_cycle_o,
    output logic                                wb_strobe_o,
    input  logic                                wb_stall_i,
    input  logic                                wb_ack_i,
    input  logic                                col_80_mode_i,  // 0 = 40 col, 1 = 80 col
    input  logic                                gfx_mode_i,     // 0 = graphics, 1 = text
    input  video_pkg::char_pos_t                pos_i,
    input  logic                                pos_valid_i,
    output logic                                pos_ready_o,
    output video_pkg::glyph_pair_t              glyph_o,
    output logic                                glyph_valid_o,
    input  logic                                glyph_ready_i
);
    import video_pkg::*;

    char_pos_t                pos_q;                    // Position being fetched
    logic                     busy_q;                   // Fetch in progress
    fetch_stage_e             fetch_stage;
    wb_state_e                wb_state;
    logic [DATA_WIDTH-1:0]    fetch_data [4];           // One byte per stage
    logic [WB_ADDR_WIDTH-1:0] addrs [4];                // Address per stage

    logic pos_take;
    logic issue_req;
    logic take_ack;

    assign wb_data_o   = '0;
    assign wb_we_o     = 1'b0;
    assign pos_ready_o = !busy_q && !glyph_valid_o;     // Wait until glyph is gone
    assign pos_take    = pos_valid_i && pos_ready_o;
    assign issue_req   = (wb_state == WB_IDLE) && busy_q && !wb_stall_i;
    assign take_ack    = (wb_state == WB_AWAIT_ACK) && wb_ack_i;

    // ROM addresses depend on the code byte from the stage before
    always_comb begin
        addrs[EVEN_RAM] = wb_vram_addr(col_80_mode_i
            ? {pos_q.ma[9:0], 1'b0}                     // Even half of pair
            : pos_q.ma[10:0]);                          // One character per ma
        addrs[EVEN_ROM] = wb_vrom_addr({gfx_mode_i, fetch_data[EVEN_RAM][6:0], pos_q.ra[2:0]});
        addrs[ODD_RAM]  = wb_vram_addr({pos_q.ma[9:0], 1'b1});
        addrs[ODD_ROM]  = wb_vrom_addr({gfx_mode_i, fetch_data[ODD_RAM][6:0], pos_q.ra[2:0]});
    end

    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            busy_q        <= 1'b0;
            fetch_stage   <= EVEN_RAM;
            wb_state      <= WB_IDLE;
            glyph_valid_o <= 1'b0;
            wb_cycle_o    <= 1'b0;
            wb_strobe_o   <= 1'b0;
        end else begin
            wb_strobe_o <= 1'b0;                        // Strobe lasts one cycle
            if (glyph_valid_o && glyph_ready_i) begin
                glyph_valid_o <= 1'b0;
            end
            if (pos_take) begin
                busy_q      <= 1'b1;
                fetch_stage <= EVEN_RAM;
            end

            case (wb_state)
                WB_IDLE: begin
                    if (issue_req) begin
                        wb_cycle_o  <= 1'b1;            // Held from here on
                        wb_strobe_o <= 1'b1;
                        wb_state    <= WB_AWAIT_ACK;
                    end
                end

                WB_AWAIT_ACK: begin
                    if (wb_ack_i) begin
                        wb_state <= WB_IDLE;
                        if (fetch_stage == ODD_ROM) begin
                            busy_q        <= 1'b0;      // Pair complete
                            glyph_valid_o <= 1'b1;
                        end else begin
                            fetch_stage <= fetch_stage_e'(fetch_stage + 2'd1);
                        end
                    end
                end

                default: wb_state <= WB_IDLE;
            endcase
        end
    end

    always_ff @(posedge wb_clock_i) begin
        if (pos_take) begin
            pos_q <= pos_i;
        end
        if (issue_req) begin
            wb_addr_o <= addrs[fetch_stage];
        end
        if (take_ack) begin
            fetch_data[fetch_stage] <= wb_data_i;
        end
    end

    always_comb begin
        glyph_o.even_row    = fetch_data[EVEN_ROM];
        glyph_o.odd_row     = fetch_data[ODD_ROM];
        glyph_o.even_rev    = fetch_data[EVEN_RAM][7];  // Bit 7 of code inverts
        glyph_o.odd_rev     = fetch_data[ODD_RAM][7];
        glyph_o.line_start  = pos_q.line_start;
        glyph_o.frame_start = pos_q.frame_start;
    end

endmodule

`default_nettype wire

/* rtl/pixel_serializer.sv */
// Pixel serializer for the character video path.
// Loads one glyph pair as a 16-bit pattern and shifts it out MSB first.
// 80-column shows even then odd glyph. 40-column shows the even glyph doubled.

`default_nettype none

module pixel_serializer (
    input  logic                   wb_clock_i,
    input  logic                   reset_i,
    input  logic                   col_80_mode_i,   // 0 = 40 col, 1 = 80 col
    input  video_pkg::glyph_pair_t glyph_i,
    input  logic                   glyph_valid_i,
    output logic                   glyph_ready_o,
    output video_pkg::pixel_t      pixel_o,
    output logic                   pixel_valid_o,
    input  logic                   pixel_ready_i
);
    logic [15:0] shift_q;                           // Pixels left, MSB is current
    logic [3:0]  count_q;                           // Pixels left minus one
    logic        line_start_q;
    logic        frame_start_q;

    logic [7:0]  even_bits;
    logic [7:0]  odd_bits;
    logic [15:0] doubled;
    logic [15:0] pattern;
    logic        load;
    logic        pixel_take;

    assign pixel_take    = pixel_valid_o && pixel_ready_i;
    assign glyph_ready_o = !pixel_valid_o || (pixel_take && (count_q == 4'd0));
    assign load          = glyph_valid_i && glyph_ready_o;

    always_comb begin
        even_bits = glyph_i.even_row ^ {8{glyph_i.even_rev}};   // Reverse video
        odd_bits  = glyph_i.odd_row ^ {8{glyph_i.odd_rev}};
        for (int i = 0; i < 8; i++) begin
            doubled[2*i]     = even_bits[i];        // Each bit twice for 40 col
            doubled[2*i + 1] = even_bits[i];
        end
        pattern = col_80_mode_i ? {even_bits, odd_bits} : doubled;
    end

    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            pixel_valid_o <= 1'b0;
            count_q       <= '0;
        end else if (load) begin
            pixel_valid_o <= 1'b1;
            count_q       <= 4'd15;                 // Sixteen pixels per pair
        end else if (pixel_take) begin
            if (count_q == 4'd0) begin
                pixel_valid_o <= 1'b0;              // Pattern drained
            end else begin
                count_q <= count_q - 4'd1;
            end
        end
    end

    always_ff @(posedge wb_clock_i) begin
        if (load) begin
            shift_q       <= pattern;
            line_start_q  <= glyph_i.line_start;
            frame_start_q <= glyph_i.frame_start;
        end else if (pixel_take) begin
            shift_q       <= {shift_q[14:0], 1'b0};
            line_start_q  <= 1'b0;                  // Flags only on first pixel
            frame_start_q <= 1'b0;
        end
    end

    always_comb begin
        pixel_o.value       = shift_q[15];
        pixel_o.line_start  = line_start_q;
        pixel_o.frame_start = frame_start_q;
    end

endmodule

`default_nettype wire

/* rtl/video_top.sv */
// Top level of the character video path.
// Timing feeds the Wishbone fetch, and the fetch feeds the pixel serializer.
// Screen geometry is set here and passed down to the timing generator.

`default_nettype none

module video_top #(
    parameter int PAIRS_PER_LINE = 20,                              // Pairs per scan line
    parameter int TEXT_ROWS      = 25                               // Text rows per frame
) (
    input  logic                                wb_clock_i,
    input  logic                                reset_i,
    output logic [video_pkg::WB_ADDR_WIDTH-1:0] wb_addr_o,
    output logic [video_pkg::DATA_WIDTH-1:0]    wb_data_o,
    input  logic [video_pkg::DATA_WIDTH-1:0]    wb_data_i,
    output logic                                wb_we_o,
    output logic                                wb_cycle_o,
    output logic                                wb_strobe_o,
    input  logic                                wb_stall_i,
    input  logic                                wb_ack_i,
    input  logic                                col_80_mode_i,  // 0 = 40 col, 1 = 80 col
    input  logic                                gfx_mode_i,     // 0 = graphics, 1 = text
    output video_pkg::pixel_t                   pixel_o,
    output logic                                pixel_valid_o,
    input  logic                                pixel_ready_i
);
    import video_pkg::*;

    char_pos_t   pos;                                               // Timing to fetch
    logic        pos_valid;
    logic        pos_ready;
    glyph_pair_t glyph;                                             // Fetch to serializer
    logic        glyph_valid;
    logic        glyph_ready;

    crtc_timing #(
        .PAIRS_PER_LINE (PAIRS_PER_LINE),
        .TEXT_ROWS      (TEXT_ROWS)
    ) i_timing (
        .wb_clock_i     (wb_clock_i),
        .reset_i        (reset_i),
        .pos_o          (pos),
        .pos_valid_o    (pos_valid),
        .pos_ready_i    (pos_ready)
    );

    video_fetch i_fetch (
        .wb_clock_i     (wb_clock_i),
        .reset_i        (reset_i),
        .wb_addr_o      (wb_addr_o),
        .wb_data_o      (wb_data_o),
        .wb_data_i      (wb_data_i),
        .wb_we_o        (wb_we_o),
        .wb_cycle_o     (wb_cycle_o),
        .wb_strobe_o    (wb_strobe_o),
        .wb_stall_i     (wb_stall_i),
        .wb_ack_i       (wb_ack_i),
        .col_80_mode_i  (col_80_mode_i),
        .gfx_mode_i     (gfx_mode_i),
        .pos_i          (pos),
        .pos_valid_i    (pos_valid),
        .pos_ready_o    (pos_ready),
        .glyph_o        (glyph),
        .glyph_valid_o  (glyph_valid),
        .glyph_ready_i  (glyph_ready)
    );

    pixel_serializer i_serializer (
        .wb_clock_i     (wb_clock_i),
        .reset_i        (reset_i),
        .col_80_mode_i  (col_80_mode_i),
        .glyph_i        (glyph),
        .glyph_valid_i  (glyph_valid),
        .glyph_ready_o  (glyph_ready),
        .pixel_o        (pixel_o),
        .pixel_valid_o  (pixel_valid_o),
        .pixel_ready_i  (pixel_ready_i)
    );

endmodule

`default_nettype wire

/* test/wb_vmem_model.sv */
// Wishbone pipelined slave holding video RAM and character ROM for the testbench.
// Contents come from $random with a fixed seed. Stall toggles at random,
// and each read is acked 1 to 3 cycles after its strobe is seen.

`default_nettype none

module wb_vmem_model #(
    parameter int SEED = 32'h9c3a                       // Fill and timing seed
) (
    input  logic                                wb_clock_i,
    input  logic                                reset_i,
    input  logic [video_pkg::WB_ADDR_WIDTH-1:0] wb_addr_i,
    input  logic                                wb_we_i,
    input  logic                                wb_cycle_i,
    input  logic                                wb_strobe_i,
    output logic [video_pkg::DATA_WIDTH-1:0]    wb_data_o,
    output logic                                wb_stall_o,
    output logic                                wb_ack_o
);
    logic [7:0]  vram [2048];                           // Character codes
    logic [7:0]  vrom [2048];                           // Glyph rows, text and graphics halves
    logic [16:0] addr_q;                                // Address of the pending read
    logic [7:0]  data_q  = 8'h00;
    logic        stall_q = 1'b0;
    logic        ack_q   = 1'b0;
    logic        pending = 1'b0;                        // Read accepted, ack not yet given
    int          wait_cnt;
    int          seed;

    assign wb_data_o  = data_q;
    assign wb_stall_o = stall_q;
    assign wb_ack_o   = ack_q;

    // Bit 16 picks the ROM window, otherwise the RAM window
    function automatic logic [7:0] read_byte(input logic [16:0] addr);
        if (addr[16]) begin
            return vrom[addr[10:0]];
        end
        return vram[addr[10:0]];
    endfunction

    initial begin
        seed = SEED;
        for (int i = 0; i < 2048; i++) begin
            vram[i] = 8'($random(seed));
            vrom[i] = 8'($random(seed));
        end
    end

    always @(posedge wb_clock_i) begin
        if (reset_i) begin
            stall_q <= 1'b0;
            ack_q   <= 1'b0;
            pending <= 1'b0;
        end else begin
            stall_q <= (($random(seed) & 3) == 0);      // Stall about one cycle in four
            ack_q   <= 1'b0;                            // Ack is a single pulse
            if (wb_cycle_i && wb_strobe_i && !wb_we_i) begin
                addr_q   <= wb_addr_i;
                wait_cnt <= $unsigned($random(seed)) % 3;
                pending  <= 1'b1;
            end else if (pending) begin
                if (wait_cnt == 0) begin
                    ack_q   <= 1'b1;
                    data_q  <= read_byte(addr_q);
                    pending <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* test/tb_video_top.sv */
// Testbench for the character video path.
// Runs video_top against the Wishbone memory model in each column and ROM mode.
// Each accepted pixel and each bus request is checked against a walk of the screen.

`default_nettype none

module tb_video_top;
    import video_pkg::*;

    localparam int SEED             = 32'h9c3a;
    localparam int PAIRS_PER_LINE   = 4;
    localparam int TEXT_ROWS        = 2;
    localparam int RESET_CYCLES     = 16;
    localparam int PIXELS_PER_FRAME = PAIRS_PER_LINE * TEXT_ROWS * 8 * 16;
    localparam int TOTAL_FRAMES     = 5;                // Frames over all tests
    localparam int TIMEOUT_CYCLES   = TOTAL_FRAMES * PIXELS_PER_FRAME * 8 + 4 * (RESET_CYCLES + 1);

    typedef struct packed {
        int pair;                                       // Pair index within the line
        int ra;                                         // Raster row
        int row;                                        // Text row
    } walk_t;

    logic                     wb_clock_i = 1'b0;
    logic                     reset_i;
    logic [WB_ADDR_WIDTH-1:0] wb_addr_o;
    logic [DATA_WIDTH-1:0]    wb_data_o;
    logic [DATA_WIDTH-1:0]    wb_data_i;
    logic                     wb_we_o;
    logic                     wb_cycle_o;
    logic                     wb_strobe_o;
    logic                     wb_stall_i;
    logic                     wb_ack_i;
    logic                     col_80_mode_i;
    logic                     gfx_mode_i;
    pixel_t                   pixel_o;
    logic                     pixel_valid_o;
    logic                     pixel_ready_i;

    int                       seed;
    int                       cycle_count  = 0;
    int                       pixel_errors = 0;
    int                       bus_errors   = 0;
    int                       tests_run    = 0;
    int                       tests_passed = 0;
    walk_t                    pix_pos;                  // Pair of the next expected pixel
    int                       pix_bit;                  // Pixel index within the pair
    walk_t                    bus_pos;                  // Pair of the next expected request
    logic [1:0]               bus_stage;                // Even code, even row, odd code, odd row
    logic [WB_ADDR_WIDTH-1:0] exp_addr;
    logic                     reset_q = 1'b0;           // Reset seen at the previous sample
    logic                     cycle_up = 1'b0;          // A request has gone out since reset

    video_top #(
        .PAIRS_PER_LINE (PAIRS_PER_LINE),
        .TEXT_ROWS      (TEXT_ROWS)
    ) i_dut (
        .wb_clock_i     (wb_clock_i),
        .reset_i        (reset_i),
        .wb_addr_o      (wb_addr_o),
        .wb_data_o      (wb_data_o),
        .wb_data_i      (wb_data_i),
        .wb_we_o        (wb_we_o),
        .wb_cycle_o     (wb_cycle_o),
        .wb_strobe_o    (wb_strobe_o),
        .wb_stall_i     (wb_stall_i),
        .wb_ack_i       (wb_ack_i),
        .col_80_mode_i  (col_80_mode_i),
        .gfx_mode_i     (gfx_mode_i),
        .pixel_o        (pixel_o),
        .pixel_valid_o  (pixel_valid_o),
        .pixel_ready_i  (pixel_ready_i)
    );

    wb_vmem_model #(
        .SEED           (SEED)
    ) i_mem (
        .wb_clock_i     (wb_clock_i),
        .reset_i        (reset_i),
        .wb_addr_i      (wb_addr_o),
        .wb_we_i        (wb_we_o),
        .wb_cycle_i     (wb_cycle_o),
        .wb_strobe_i    (wb_strobe_o),
        .wb_data_o      (wb_data_i),
        .wb_stall_o     (wb_stall_i),
        .wb_ack_o       (wb_ack_i)
    );

    always #20 wb_clock_i = ~wb_clock_i;                // Period 40

    always @(posedge wb_clock_i) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic [7:0] mem_byte(input logic [WB_ADDR_WIDTH-1:0] addr);
        if (addr[16]) begin
            return i_mem.vrom[addr[10:0]];
        end
        return i_mem.vram[addr[10:0]];
    endfunction

    // Odd code sits at 2*ma+1; even code at 2*ma in 80 col, at ma in 40 col
    function automatic logic [WB_ADDR_WIDTH-1:0] code_addr(input walk_t p, input logic odd);
        logic [13:0] ma;
        ma = 14'(p.row * PAIRS_PER_LINE + p.pair);
        if (odd || col_80_mode_i) begin
            return wb_vram_addr({ma[9:0], odd});
        end
        return wb_vram_addr(ma[10:0]);
    endfunction

    function automatic logic [WB_ADDR_WIDTH-1:0] row_addr(input walk_t p, input logic odd);
        logic [7:0] code;
        code = mem_byte(code_addr(p, odd));
        return wb_vrom_addr({gfx_mode_i, code[6:0], 3'(p.ra)});   // Bit 7 not in ROM address
    endfunction

    // Glyph row as it should appear, inverted when code bit 7 is set
    function automatic logic [7:0] shown_row(input walk_t p, input logic odd);
        logic [7:0] code;
        code = mem_byte(code_addr(p, odd));
        return mem_byte(row_addr(p, odd)) ^ {8{code[7]}};
    endfunction

    function automatic walk_t next_pos(input walk_t p);
        walk_t n;
        n = p;
        if (p.pair < PAIRS_PER_LINE - 1) begin
            n.pair = p.pair + 1;
        end else begin
            n.pair = 0;
            n.ra   = (p.ra + 1) % 8;
            if (p.ra == 7) begin
                n.row = (p.row + 1) % TEXT_ROWS;        // Frame wraps after the last row
            end
        end
        return n;
    endfunction

    task automatic check_pixel();
        logic [7:0] even_row;
        logic [7:0] odd_row;
        logic       exp_value;
        logic       exp_line;
        logic       exp_frame;
        even_row = shown_row(pix_pos, 1'b0);
        odd_row  = shown_row(pix_pos, 1'b1);
        if (col_80_mode_i) begin
            exp_value = (pix_bit < 8) ? even_row[7 - pix_bit] : odd_row[15 - pix_bit];
        end else begin
            exp_value = even_row[7 - pix_bit / 2];      // Each even bit twice and odd glyph unused
        end
        exp_line  = (pix_pos.pair == 0) && (pix_bit == 0);
        exp_frame = exp_line && (pix_pos.ra == 0) && (pix_pos.row == 0);
        if (pixel_o.value !== exp_value) begin
            $display(
                "Mismatch pixel_o.value at row %0d ra %0d pair %0d bit %0d: got %0h expected %0h",
                pix_pos.row, pix_pos.ra, pix_pos.pair, pix_bit, pixel_o.value, exp_value);
            pixel_errors++;
        end
        if (pixel_o.line_start !== exp_line) begin
            $display("Mismatch pixel_o.line_start at pair %0d bit %0d: got %0h expected %0h",
                     pix_pos.pair, pix_bit, pixel_o.line_start, exp_line);
            pixel_errors++;
        end
        if (pixel_o.frame_start !== exp_frame) begin
            $display("Mismatch pixel_o.frame_start at pair %0d bit %0d: got %0h expected %0h",
                     pix_pos.pair, pix_bit, pixel_o.frame_start, exp_frame);
            pixel_errors++;
        end
        if (pix_bit == 15) begin
            pix_bit = 0;
            pix_pos = next_pos(pix_pos);
        end else begin
            pix_bit++;
        end
    endtask

    // Every strobe must be a read at the next predicted address
    always @(negedge wb_clock_i) begin
        if (reset_i) begin
            if (reset_q && (wb_strobe_o !== 1'b0 || wb_cycle_o !== 1'b0
                            || pixel_valid_o !== 1'b0)) begin
                $display("Bus request or pixel output active while reset is held");
                bus_errors++;
            end
            bus_pos   = '0;
            bus_stage = 2'd0;
            cycle_up  = 1'b0;
        end else begin
            if (wb_strobe_o === 1'b1) begin
                cycle_up = 1'b1;                        // Cycle stays up from here on
            end
            if (cycle_up && wb_cycle_o !== 1'b1) begin
                $display("Mismatch wb_cycle_o: got %0h expected 1", wb_cycle_o);
                bus_errors++;
            end
            if (wb_strobe_o) begin
                exp_addr = bus_stage[0] ? row_addr(bus_pos, bus_stage[1])
                                        : code_addr(bus_pos, bus_stage[1]);
                if (wb_addr_o !== exp_addr) begin
                    $display("Mismatch wb_addr_o: got %0h expected %0h", wb_addr_o, exp_addr);
                    bus_errors++;
                end
                if (wb_we_o !== 1'b0) begin
                    $display("Mismatch wb_we_o: got %0h expected 0", wb_we_o);
                    bus_errors++;
                end
                if (wb_data_o !== '0) begin
                    $display("Mismatch wb_data_o: got %0h expected 0", wb_data_o);
                    bus_errors++;
                end
                if (bus_stage == 2'd3) begin
                    bus_pos = next_pos(bus_pos);
                end
                bus_stage = bus_stage + 2'd1;
            end
        end
        reset_q = reset_i;
    end

    task automatic run_test(input string name, input logic col80, input logic gfx,
                            input int frames);
        int errors_before;
        int pixels_seen;
        errors_before = pixel_errors + bus_errors;
        pixels_seen   = 0;
        @(posedge wb_clock_i);
        reset_i       <= 1'b1;
        pixel_ready_i <= 1'b0;
        col_80_mode_i <= col80;                         // Mode set while the pipeline is empty
        gfx_mode_i    <= gfx;
        repeat (RESET_CYCLES) @(posedge wb_clock_i);
        reset_i <= 1'b0;
        pix_pos = '0;
        pix_bit = 0;
        while (pixels_seen < frames * PIXELS_PER_FRAME) begin
            @(negedge wb_clock_i);
            if (pixel_valid_o && pixel_ready_i) begin   // Taken on the coming edge
                check_pixel();
                pixels_seen++;
            end
            @(posedge wb_clock_i);
            pixel_ready_i <= (($random(seed) & 3) != 0);
        end
        tests_run++;
        if (pixel_errors + bus_errors == errors_before) begin
            tests_passed++;
            $display("Test %s passed, %0d pixels checked", name, pixels_seen);
        end else begin
            $display("Test %s failed with %0d errors", name,
                     pixel_errors + bus_errors - errors_before);
        end
    endtask

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Run stopped after %0d cycles with the pixel stream unfinished", cycle_count);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        seed          = SEED;
        reset_i       <= 1'b1;
        col_80_mode_i <= 1'b1;
        gfx_mode_i    <= 1'b1;
        pixel_ready_i <= 1'b0;
        run_test("80-column text", 1'b1, 1'b1, 1);
        run_test("40-column text", 1'b0, 1'b1, 1);
        run_test("80-column graphics, frame repeat", 1'b1, 1'b0, 2);
        run_test("40-column graphics", 1'b0, 1'b0, 1);
        $display("Tests run %0d, passed %0d, pixel errors %0d, bus errors %0d",
                 tests_run, tests_passed, pixel_errors, bus_errors);
        if (pixel_errors + bus_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
rtl/video_pkg.sv
rtl/crtc_timing.sv
rtl/video_fetch.sv
rtl/pixel_serializer.sv
rtl/video_top.sv
test/wb_vmem_model.sv
test/tb_video_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build the video path testbench with Verilator and run it.
# Exits non-zero unless the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_video_top -f project.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_video_top)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
